// ==== source/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // architectural widths
    localparam int xlen = 64;
    localparam int ilen = 32;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

    // cause picked by the redirect unit, in priority order after none
    typedef enum logic [1:0] {
        redir_none,
        // jal, or a branch whose compare result is zero
        redir_jal_or_branch,
        // rs1 plus imm with bit 0 cleared
        redir_jalr,
        // exception or interrupt entry through mtvec
        redir_trap
    } redirect_e;

endpackage

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // read bus data and size fields
    localparam int bus_data_w = 64;
    localparam int rd_size_w = 8;
    localparam logic [rd_size_w-1:0] fetch_size = 8'h0F;

    // instruction queue toward decode
    localparam int ibuf_depth = 2;
    localparam int ibuf_cnt_w = $clog2(ibuf_depth + 1);
    localparam int ibuf_ptr_w = (ibuf_depth > 1) ? $clog2(ibuf_depth) : 1;

    // read bus sequencing in the fetch unit
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_addr,
        fetch_data
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== source/next_pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module next_pc_unit
    import rv_core_pkg::*;
(
    input  wire             me_jal_i,
    input  wire             me_jalr_i,
    input  wire             me_branch_i,
    input  wire             trap_i,
    input  wire  [xlen-1:0] me_pc_i,
    input  wire  [xlen-1:0] me_imm_i,
    input  wire  [xlen-1:0] me_r1data_i,
    input  wire  [xlen-1:0] me_alu_res_i,
    input  wire  [xlen-1:0] csr_mtvec_i,
    output logic            redirect_valid_o,
    output logic [xlen-1:0] redirect_pc_o
);

    redirect_e       cause;
    logic            br_taken;
    logic [xlen-1:0] jalr_sum;

    // branch compare result of zero means taken
    assign br_taken = me_branch_i && (me_alu_res_i == '0);
    assign jalr_sum = me_r1data_i + me_imm_i;

    // jal / branch beats jalr, trap comes last
    always_comb begin
        if (me_jal_i || br_taken) begin
            cause = redir_jal_or_branch;
        end else if (me_jalr_i) begin
            cause = redir_jalr;
        end else if (trap_i) begin
            cause = redir_trap;
        end else begin
            cause = redir_none;
        end
    end

    always_comb begin
        case (cause)
            redir_jal_or_branch: redirect_pc_o = me_pc_i + me_imm_i;
            redir_jalr:          redirect_pc_o = {jalr_sum[xlen-1:1], 1'b0};
            redir_trap:          redirect_pc_o = csr_mtvec_i;
            default:             redirect_pc_o = me_pc_i;
        endcase
    end

    assign redirect_valid_o = (cause != redir_none);

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
    import rv_core_pkg::*, mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_i,
    // redirect from the memory stage
    input  wire                   redirect_valid_i,
    input  wire  [xlen-1:0]       redirect_pc_i,
    // read bus, address phase
    output logic                  rd_addr_valid_o,
    input  wire                   rd_addr_ready_i,
    output logic [xlen-1:0]       rd_addr_o,
    output logic [rd_size_w-1:0]  rd_size_o,
    // read bus, data phase
    input  wire                   rd_data_valid_i,
    output logic                  rd_data_ready_o,
    input  wire  [bus_data_w-1:0] rd_data_i,
    // instruction buffer side
    input  wire  [ibuf_cnt_w-1:0] ibuf_count_i,
    output logic                  push_o,
    output logic [ilen-1:0]       push_inst_o,
    output logic [xlen-1:0]       push_pc_o
);

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] rd_addr_q;
    logic            stale_q;
    logic            can_start;
    logic            addr_fire;
    logic            data_fire;

    assign addr_fire = rd_addr_valid_o && rd_addr_ready_i;
    assign data_fire = rd_data_valid_i && rd_data_ready_o;

    // one read at a time, so in idle the only credit in use is the buffer itself
    // a redirect empties the buffer this cycle
    assign can_start = redirect_valid_i || (ibuf_count_i < ibuf_cnt_w'(ibuf_depth));

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_idle: begin
                if (can_start) begin
                    state_d = fetch_addr;
                end
            end
            fetch_addr: begin
                if (rd_addr_ready_i) begin
                    state_d = fetch_data;
                end
            end
            fetch_data: begin
                if (rd_data_valid_i) begin
                    state_d = fetch_idle;
                end
            end
            default: state_d = fetch_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= fetch_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // next address to fetch; redirect wins over a response in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= reset_pc;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (data_fire && !stale_q) begin
            pc_q <= rd_addr_q + xlen'(4);
        end
    end

    // latched on entry to addr, then held until the slave takes it
    always_ff @(posedge clk) begin
        if (state_q == fetch_idle && can_start) begin
            rd_addr_q <= redirect_valid_i ? redirect_pc_i : pc_q;
        end
    end

    // read in flight during a redirect belongs to the old stream
    always_ff @(posedge clk) begin
        if (rst_i) begin
            stale_q <= 1'b0;
        end else if (data_fire) begin
            stale_q <= 1'b0;
        end else if (redirect_valid_i && state_q != fetch_idle) begin
            stale_q <= 1'b1;
        end
    end

    assign rd_addr_valid_o = (state_q == fetch_addr);
    assign rd_addr_o       = rd_addr_q;
    assign rd_size_o       = fetch_size;
    assign rd_data_ready_o = (state_q == fetch_data);

    // drop stale data, and data that arrives with a redirect
    assign push_o      = data_fire && !stale_q && !redirect_valid_i;
    // bit 2 picks the upper word of the doubleword
    assign push_inst_o = rd_addr_q[2] ? rd_data_i[bus_data_w-1 -: ilen] : rd_data_i[ilen-1:0];
    assign push_pc_o   = rd_addr_q;

endmodule

`default_nettype wire

// ==== source/inst_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_buffer
    import rv_core_pkg::*, mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   flush_i,
    input  wire                   push_i,
    input  wire  [ilen-1:0]       push_inst_i,
    input  wire  [xlen-1:0]       push_pc_i,
    input  wire                   dec_ready_i,
    output logic [ibuf_cnt_w-1:0] count_o,
    output logic                  inst_valid_o,
    output logic [ilen-1:0]       inst_o,
    output logic [xlen-1:0]       pc_o
);

    logic [ilen-1:0]       inst_mem [ibuf_depth];
    logic [xlen-1:0]       pc_mem   [ibuf_depth];
    logic [ibuf_ptr_w-1:0] wr_ptr_q;
    logic [ibuf_ptr_w-1:0] rd_ptr_q;
    logic [ibuf_cnt_w-1:0] count_q;
    logic                  push_ok;
    logic                  pop;

    function automatic logic [ibuf_ptr_w-1:0] ptr_inc(input logic [ibuf_ptr_w-1:0] ptr);
        if (ptr == ibuf_ptr_w'(ibuf_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ok = push_i && !flush_i;
    assign pop     = inst_valid_o && dec_ready_i;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head entry is already dead when a redirect is seen
    assign inst_valid_o = (count_q != '0) && !flush_i;
    assign inst_o       = inst_mem[rd_ptr_q];
    assign pc_o         = pc_mem[rd_ptr_q];
    assign count_o      = count_q;

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top
    import rv_core_pkg::*, mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_i,
    // memory stage control flow
    input  wire                   me_jal_i,
    input  wire                   me_jalr_i,
    input  wire                   me_branch_i,
    input  wire                   trap_i,
    input  wire  [xlen-1:0]       me_pc_i,
    input  wire  [xlen-1:0]       me_imm_i,
    input  wire  [xlen-1:0]       me_r1data_i,
    input  wire  [xlen-1:0]       me_alu_res_i,
    input  wire  [xlen-1:0]       csr_mtvec_i,
    // instruction read bus
    output logic                  rd_addr_valid_o,
    input  wire                   rd_addr_ready_i,
    output logic [xlen-1:0]       rd_addr_o,
    output logic [rd_size_w-1:0]  rd_size_o,
    input  wire                   rd_data_valid_i,
    output logic                  rd_data_ready_o,
    input  wire  [bus_data_w-1:0] rd_data_i,
    // decode side
    input  wire                   dec_ready_i,
    output logic                  inst_valid_o,
    output logic [ilen-1:0]       inst_o,
    output logic [xlen-1:0]       pc_o
);

    logic                  redirect_valid;
    logic [xlen-1:0]       redirect_pc;
    logic                  push;
    logic [ilen-1:0]       push_inst;
    logic [xlen-1:0]       push_pc;
    logic [ibuf_cnt_w-1:0] ibuf_count;

    next_pc_unit u_next_pc (
        .me_jal_i, .me_jalr_i, .me_branch_i, .trap_i,
        .me_pc_i, .me_imm_i, .me_r1data_i, .me_alu_res_i, .csr_mtvec_i,
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    fetch_unit u_fetch (
        .clk, .rst_i,
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .rd_addr_valid_o, .rd_addr_ready_i, .rd_addr_o, .rd_size_o,
        .rd_data_valid_i, .rd_data_ready_o, .rd_data_i,
        .ibuf_count_i     (ibuf_count),
        .push_o           (push),
        .push_inst_o      (push_inst),
        .push_pc_o        (push_pc)
    );

    // redirect doubles as the buffer flush
    inst_buffer u_ibuf (
        .clk, .rst_i,
        .flush_i     (redirect_valid),
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .dec_ready_i,
        .count_o     (ibuf_count),
        .inst_valid_o, .inst_o, .pc_o
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_o
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 16 rising edges, released just after the last one
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk);
        #2 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/mem_slave_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_slave_model
    import rv_core_pkg::*, mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   rd_addr_valid_i,
    output logic                  rd_addr_ready_o,
    input  wire  [xlen-1:0]       rd_addr_i,
    output logic                  rd_data_valid_o,
    input  wire                   rd_data_ready_i,
    output logic [bus_data_w-1:0] rd_data_o
);

    localparam logic [31:0] fill_pattern = 32'h5a3c_96e1;

    // low half holds the word at A, high half the word at A+4
    function automatic logic [bus_data_w-1:0] word_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] base;
        base = {addr[xlen-1:3], 3'b000};
        return {base[31:0] + 32'd4 ^ fill_pattern, base[31:0] ^ fill_pattern};
    endfunction

    initial begin
        rd_addr_ready_o = 1'b0;
        rd_data_valid_o = 1'b0;
        rd_data_o       = '0;
    end

    // one read at a time, each phase delayed by 0 to 3 cycles
    always begin
        int delay;
        logic [xlen-1:0] addr;
        @(posedge clk);
        #2;
        if (!rst_i && rd_addr_valid_i) begin
            delay = int'($urandom_range(3, 0));
            repeat (delay) begin
                @(posedge clk);
                #2;
            end
            addr = rd_addr_i;
            rd_addr_ready_o = 1'b1;
            @(posedge clk);
            #2 rd_addr_ready_o = 1'b0;
            delay = int'($urandom_range(3, 0));
            repeat (delay) begin
                @(posedge clk);
                #2;
            end
            rd_data_o = word_at(addr);
            rd_data_valid_o = 1'b1;
            // data valid stays up until the transfer
            while (!rd_data_ready_i) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2 rd_data_valid_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tests/fetch_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions
    import rv_core_pkg::*, mem_bus_pkg::*;
(
    input wire                  clk,
    input wire                  rst_i,
    input wire                  rd_addr_valid_i,
    input wire                  rd_addr_ready_i,
    input wire [xlen-1:0]       rd_addr_i,
    input wire                  rd_data_ready_i,
    input wire [ibuf_cnt_w-1:0] count_i,
    input wire                  inst_valid_i
);

    // address held until the slave takes it
    a_addr_hold: assert property (@(posedge clk) disable iff (rst_i)
        rd_addr_valid_i && !rd_addr_ready_i |=> rd_addr_valid_i && $stable(rd_addr_i))
        else $error("read address changed while waiting for ready");

    // data ready only rises right after an address handshake
    a_ready_order: assert property (@(posedge clk) disable iff (rst_i)
        rd_data_ready_i && !$past(rd_data_ready_i) |-> $past(rd_addr_valid_i && rd_addr_ready_i))
        else $error("data ready raised before the address was accepted");

    a_count_max: assert property (@(posedge clk) disable iff (rst_i)
        count_i <= ibuf_cnt_w'(ibuf_depth))
        else $error("instruction buffer count above its depth");

    a_reset_valid: assert property (@(posedge clk) rst_i |=> !inst_valid_i)
        else $error("instruction valid high right after reset");

endmodule

bind fetch_top fetch_assertions u_assertions (
    .clk             (clk),
    .rst_i           (rst_i),
    .rd_addr_valid_i (rd_addr_valid_o),
    .rd_addr_ready_i (rd_addr_ready_i),
    .rd_addr_i       (rd_addr_o),
    .rd_data_ready_i (rd_data_ready_o),
    .count_i         (ibuf_count),
    .inst_valid_i    (inst_valid_o)
);

`default_nettype wire

// ==== tests/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_tb
    import rv_core_pkg::*, mem_bus_pkg::*;
;

    localparam logic [31:0] fill_pattern = 32'h5a3c_96e1;
    localparam int cycle_limit = 16 + 400 * 6;

    logic clk;
    logic rst_i;
    logic me_jal, me_jalr, me_branch, trap;
    logic [xlen-1:0] me_pc, me_imm, me_r1data, me_alu_res, csr_mtvec;
    logic rd_addr_valid, rd_addr_ready, rd_data_valid, rd_data_ready;
    logic [xlen-1:0] rd_addr;
    logic [rd_size_w-1:0] rd_size;
    logic [bus_data_w-1:0] rd_data;
    logic dec_ready, inst_valid;
    logic [ilen-1:0] inst;
    logic [xlen-1:0] pc;

    // reference model state
    logic [xlen-1:0] exp_pc;
    logic redir_pending;
    logic [xlen-1:0] redir_target;
    int accepted;
    int errors;
    int cycles;
    int tests_run;

    tb_clock_gen u_clk (.clk(clk), .rst_o(rst_i));

    fetch_top dut (
        .clk, .rst_i,
        .me_jal_i(me_jal), .me_jalr_i(me_jalr), .me_branch_i(me_branch), .trap_i(trap),
        .me_pc_i(me_pc), .me_imm_i(me_imm), .me_r1data_i(me_r1data),
        .me_alu_res_i(me_alu_res), .csr_mtvec_i(csr_mtvec),
        .rd_addr_valid_o(rd_addr_valid), .rd_addr_ready_i(rd_addr_ready),
        .rd_addr_o(rd_addr), .rd_size_o(rd_size),
        .rd_data_valid_i(rd_data_valid), .rd_data_ready_o(rd_data_ready), .rd_data_i(rd_data),
        .dec_ready_i(dec_ready), .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc)
    );

    mem_slave_model u_mem (
        .clk, .rst_i,
        .rd_addr_valid_i(rd_addr_valid), .rd_addr_ready_o(rd_addr_ready), .rd_addr_i(rd_addr),
        .rd_data_valid_o(rd_data_valid), .rd_data_ready_i(rd_data_ready), .rd_data_o(rd_data)
    );

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic run_until(input int n);
        int target;
        target = accepted + n;
        while (accepted < target) begin
            step();
            dec_ready = 1'($urandom_range(1, 0));
        end
    endtask

    // one-cycle pulse on the memory-stage inputs
    task automatic pulse(input logic jal, input logic jalr, input logic br, input logic trp,
                         input logic [63:0] alu, input logic taken, input logic [63:0] target);
        step();
        me_jal = jal;
        me_jalr = jalr;
        me_branch = br;
        trap = trp;
        me_alu_res = alu;
        redir_pending = taken;
        redir_target = target;
        step();
        {me_jal, me_jalr, me_branch, trap} = 4'b0000;
        redir_pending = 1'b0;
    endtask

    task automatic pick_operands();
        me_pc = reset_pc + 64'({$urandom_range(1023, 0), 2'b00});
        me_imm = 64'({$urandom_range(511, 0), 2'b00});
        me_r1data = reset_pc + 64'({$urandom_range(2047, 0), 2'b01});
        csr_mtvec = reset_pc + 64'({$urandom_range(255, 0), 4'b0000});
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // transfer happens at the next edge if both are high now
    always @(negedge clk) begin
        if (!rst_i) begin
            if (rd_addr_valid) begin
                check_value("rd_size_o", 64'(rd_size), 64'h0F);
            end
            if (redir_pending) begin
                check_value("inst_valid_o", 64'(inst_valid), 64'd0);
                exp_pc = redir_target;
            end else if (inst_valid && dec_ready) begin
                check_value("pc_o", pc, exp_pc);
                check_value("inst_o", 64'(inst), 64'(exp_pc[31:0] ^ fill_pattern));
                exp_pc = exp_pc + 64'd4;
                accepted++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int err0;
        void'($urandom(32'hd7b0_f620));
        {me_jal, me_jalr, me_branch, trap} = 4'b0000;
        me_pc = '0;
        me_imm = '0;
        me_r1data = '0;
        me_alu_res = '0;
        csr_mtvec = '0;
        dec_ready = 1'b0;
        exp_pc = reset_pc;
        redir_pending = 1'b0;
        redir_target = '0;
        accepted = 0;
        errors = 0;
        cycles = 0;
        tests_run = 0;
        wait (rst_i === 1'b0);

        err0 = errors;
        run_until(50);
        report("sequential_fetch", err0);

        err0 = errors;
        repeat (12) begin
            pick_operands();
            case ($urandom_range(2, 0))
                0: pulse(1, 0, 0, 0, 64'd1, 1, me_pc + me_imm);
                1: pulse(0, 0, 1, 0, 64'd0, 1, me_pc + me_imm);
                default: pulse(0, 0, 1, 0, 64'($urandom_range(99, 1)), 0, '0);
            endcase
            run_until(3);
        end
        report("jal_and_branch", err0);

        err0 = errors;
        pick_operands();
        pulse(0, 1, 0, 0, 64'd1, 1, (me_r1data + me_imm) & ~64'd1);
        run_until(4);
        pick_operands();
        pulse(0, 1, 0, 1, 64'd1, 1, (me_r1data + me_imm) & ~64'd1);
        run_until(4);
        report("jalr", err0);

        err0 = errors;
        pick_operands();
        pulse(0, 0, 0, 1, 64'd1, 1, csr_mtvec);
        run_until(4);
        pick_operands();
        pulse(1, 0, 0, 1, 64'd1, 1, me_pc + me_imm);
        run_until(4);
        report("trap", err0);

        err0 = errors;
        repeat (8) begin
            dec_ready = 1'b0;
            repeat ($urandom_range(20, 3)) step();
            run_until(3);
        end
        report("decode_stall", err0);

        err0 = errors;
        repeat (5) begin
            // wait for a read that is past its address phase
            @(negedge clk);
            while (!(rd_data_ready && !rd_data_valid)) begin
                step();
                dec_ready = 1'($urandom_range(1, 0));
                @(negedge clk);
            end
            step();
            pick_operands();
            me_alu_res = 64'd1;
            me_jal = 1'b1;
            redir_pending = 1'b1;
            redir_target = me_pc + me_imm;
            step();
            me_jal = 1'b0;
            redir_pending = 1'b0;
            run_until(3);
        end
        report("redirect_in_flight", err0);

        $display("done: %0d tests, %0d instructions, %0d errors", tests_run, accepted, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/rv_core_pkg.sv
source/mem_bus_pkg.sv
source/next_pc_unit.sv
source/fetch_unit.sv
source/inst_buffer.sv
source/fetch_top.sv
tests/tb_clock_gen.sv
tests/mem_slave_model.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fetch_tb -f all.f

output="$(./obj_dir/Vfetch_tb)"
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi
